// File: common/input_pkg.sv
// Input path types for the cabinet glue
// Keyboard scan codes, held button set and joystick port layout

package input_pkg;

	// ========================================================================
	// PS/2 scan codes the cabinet reacts to
	// ========================================================================
	typedef enum logic [7:0] {
		key_up    = 8'h75,
		key_down  = 8'h72,
		key_left  = 8'h6b,
		key_right = 8'h74,
		key_esc   = 8'h76, // Coin
		key_f1    = 8'h05, // One player start
		key_f2    = 8'h06, // Two player start
		key_ctrl  = 8'h14,
		key_alt   = 8'h11,
		key_space = 8'h29
	} key_code_e;

	// Held keyboard buttons, one level per key
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic coin;
		logic start1;
		logic start2;
		logic fire1;   // Space
		logic fire2;   // Alt
		logic fire3;   // Ctrl
	} buttons_t;

	// One joystick port, right in bit 0
	typedef struct packed {
		logic [1:0] spare;
		logic       fire2;
		logic       fire1;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joystick_t;

endpackage

// File: common/av_pkg.sv
// Video and audio path types for the cabinet glue
// Core pixel format, sync and blank bundle, scanline dimming levels

package av_pkg;

	// ========================================================================
	// Core video
	// ========================================================================

	// 3-3-2 colour straight from the core
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
	} core_pixel_t;

	// All active high, as the core drives them
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic hblank;
		logic vblank;
	} video_timing_t;

	// Amount of dimming on odd lines
	typedef enum logic [1:0] {
		off   = 2'd0,
		pct25 = 2'd1,
		pct50 = 2'd2,
		pct75 = 2'd3
	} scanline_e;

endpackage

// File: design/clock_enables.sv
// Clock enable generator
// Single-cycle 6 MHz and 4 MHz enables for the game core, divided from clk_sys

`timescale 1ns/10ps

module clock_enables (
	input  logic clk_sys,
	input  logic rst,
	output logic ce_6m,
	output logic ce_4m
);

	logic [1:0] div4;   // Free running, wraps at 4
	logic [2:0] div6;   // Wraps at 6

	// Counters start at 1 so the first pulse lands a full period after reset
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			div4  <= 2'd1;
			div6  <= 3'd1;
			ce_6m <= 1'b0;
			ce_4m <= 1'b0;
		end else begin
			div4 <= div4 + 2'd1;
			if (div6 == 3'd5)
				div6 <= 3'd0;
			else
				div6 <= div6 + 3'd1;
			ce_6m <= (div4 == 2'd0);
			ce_4m <= (div6 == 3'd0);
		end
	end

	// ========================================================================
	// Checks
	// ========================================================================

	// Enables are strobes, never wider than one cycle
	a_ce_6m_single: assert property (
		@(posedge clk_sys) disable iff (rst) ce_6m |=> !ce_6m
	);

	a_ce_4m_single: assert property (
		@(posedge clk_sys) disable iff (rst) ce_4m |=> !ce_4m
	);

endmodule

// File: input/key_latch.sv
// Keyboard button latch
// Press and release strobes from the PS/2 decoder become held button levels

`timescale 1ns/10ps

module key_latch (
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                key_strobe,
	input  logic [7:0]          key_code,
	input  logic                key_pressed,
	output input_pkg::buttons_t buttons
);

	input_pkg::key_code_e code;

	assign code = input_pkg::key_code_e'(key_code);

	// One button per recognised code, everything else holds
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			buttons <= '0;
		end else if (key_strobe) begin
			case (code)
				input_pkg::key_up:    buttons.up     <= key_pressed;
				input_pkg::key_down:  buttons.down   <= key_pressed;
				input_pkg::key_left:  buttons.left   <= key_pressed;
				input_pkg::key_right: buttons.right  <= key_pressed;
				input_pkg::key_esc:   buttons.coin   <= key_pressed;
				input_pkg::key_f1:    buttons.start1 <= key_pressed;
				input_pkg::key_f2:    buttons.start2 <= key_pressed;
				input_pkg::key_ctrl:  buttons.fire3  <= key_pressed;
				input_pkg::key_alt:   buttons.fire2  <= key_pressed;
				input_pkg::key_space: buttons.fire1  <= key_pressed;
				default: ; // Unknown code, ignore
			endcase
		end
	end

	// ========================================================================
	// Checks
	// ========================================================================

	// Decoder must present a clean code with every strobe
	a_code_known: assert property (
		@(posedge clk_sys) disable iff (rst)
		key_strobe |-> !$isunknown({key_code, key_pressed})
	);

endmodule

// File: input/control_mapper.sv
// Control mapper
// Merges keyboard buttons with both joysticks, applies monitor rotation
// and registers the active-low input bytes read by the core

`timescale 1ns/10ps

module control_mapper (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  input_pkg::buttons_t  buttons,
	input  input_pkg::joystick_t joy0,
	input  input_pkg::joystick_t joy1,
	input  logic                 rotate,
	output logic [7:0]           in0_n,
	output logic [7:0]           in1_n
);

	logic any_up;
	logic any_down;
	logic any_left;
	logic any_right;
	logic m_up;
	logic m_down;
	logic m_left;
	logic m_right;
	logic m_fire;

	// Keyboard and both sticks merged per direction
	assign any_up    = buttons.up    | joy0.up    | joy1.up;
	assign any_down  = buttons.down  | joy0.down  | joy1.down;
	assign any_left  = buttons.left  | joy0.left  | joy1.left;
	assign any_right = buttons.right | joy0.right | joy1.right;

	// Rotate low means the monitor is turned, so directions turn with it
	assign m_up    = rotate ? any_up    : any_left;
	assign m_down  = rotate ? any_down  : any_right;
	assign m_left  = rotate ? any_left  : any_down;
	assign m_right = rotate ? any_right : any_up;

	assign m_fire = buttons.fire1 | joy0.fire1 | joy1.fire1;

	// Core sees zero as pressed
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			in0_n <= 8'hff;
			in1_n <= 8'hff;
		end else begin
			in0_n <= ~{2'b00, buttons.coin, m_fire, m_down, m_right, m_left, m_up};
			in1_n <= ~{1'b0, buttons.start2, buttons.start1, 5'b00000};
		end
	end

endmodule

// File: av/video_blank.sv
// Video blanking and scanline dimming
// Forces black during blanking, dims odd lines by the selected level and
// delays sync by the same single cycle as the pixel

`timescale 1ns/10ps

module video_blank (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  av_pkg::core_pixel_t   pix_in,
	input  av_pkg::video_timing_t timing_in,
	input  av_pkg::scanline_e     scanlines,
	output av_pkg::core_pixel_t   pix_out,
	output av_pkg::video_timing_t timing_out
);

	logic                hsync_d;
	logic                vsync_d;
	logic                odd_line;
	logic                blank;
	av_pkg::core_pixel_t pix_dim;

	// Scale one colour channel, blue goes through zero-extended
	function automatic logic [2:0] dim(input logic [2:0] c, input av_pkg::scanline_e lvl);
		case (lvl)
			av_pkg::pct25: dim = c - (c >> 2);
			av_pkg::pct50: dim = c >> 1;
			av_pkg::pct75: dim = c >> 2;
			default:       dim = c;
		endcase
	endfunction

	assign blank = timing_in.hblank | timing_in.vblank;

	// Parity in effect when the pixel arrives
	always_comb begin
		pix_dim = pix_in;
		if (odd_line) begin
			pix_dim.red   = dim(pix_in.red, scanlines);
			pix_dim.green = dim(pix_in.green, scanlines);
			pix_dim.blue  = 2'(dim({1'b0, pix_in.blue}, scanlines));
		end
	end

	// ========================================================================
	// Line parity tracking
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			hsync_d  <= 1'b0;
			vsync_d  <= 1'b0;
			odd_line <= 1'b0;
		end else begin
			hsync_d <= timing_in.hsync;
			vsync_d <= timing_in.vsync;
			if (timing_in.vsync && !vsync_d)
				odd_line <= 1'b0;   // Frame starts on an even line
			else if (timing_in.hsync && !hsync_d)
				odd_line <= ~odd_line;
		end
	end

	// Output stage
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			pix_out    <= '0;
			timing_out <= '0;
		end else begin
			pix_out    <= blank ? '0 : pix_dim;
			timing_out <= timing_in;
		end
	end

	// Blanked input must reach the output as black
	a_blank_black: assert property (
		@(posedge clk_sys) disable iff (rst) blank |=> (pix_out == '0)
	);

endmodule

// File: av/sigma_delta_dac.sv
// First-order sigma-delta audio DAC
// Unsigned sample in, one-bit pulse density stream out for an RC filter

`timescale 1ns/10ps

module sigma_delta_dac #(
	parameter int DAC_MSB = 15
) (
	input  logic             clk_sys,
	input  logic             rst,
	input  logic [DAC_MSB:0] dac_in,
	output logic             dac_out
);

	// Carry bit on top of the running sum
	logic [DAC_MSB+1:0] acc;
	logic [DAC_MSB+1:0] acc_next;

	// Carry from the previous sum is dropped, the remainder keeps integrating
	assign acc_next = {1'b0, acc[DAC_MSB:0]} + {1'b0, dac_in};

	assign dac_out = acc[DAC_MSB+1]; // Density of ones tracks dac_in

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			acc <= '0;
		end else begin
			acc <= acc_next;
		end
	end

endmodule

// File: design/cabinet_io_top.sv
// Cabinet I/O top level
// Clock enables, keyboard and joystick input path, video blanking and
// audio DAC wrapped around the arcade game core

`timescale 1ns/10ps

module cabinet_io_top #(
	parameter int DAC_MSB = 15
) (
	input  logic                  clk_sys,
	input  logic                  rst,

	// Keyboard events
	input  logic                  key_strobe,
	input  logic [7:0]            key_code,
	input  logic                  key_pressed,

	// Joysticks and options
	input  input_pkg::joystick_t  joy0,
	input  input_pkg::joystick_t  joy1,
	input  logic                  rotate,
	input  av_pkg::scanline_e     scanlines,

	// From the core
	input  av_pkg::core_pixel_t   core_pixel,
	input  av_pkg::video_timing_t core_timing,
	input  logic signed [8:0]     core_audio,

	// To the core
	output logic                  ce_6m,
	output logic                  ce_4m,
	output logic [7:0]            in0_n,
	output logic [7:0]            in1_n,

	// To the board
	output av_pkg::core_pixel_t   pix_out,
	output av_pkg::video_timing_t timing_out,
	output logic                  audio_out
);

	input_pkg::buttons_t buttons;
	logic [DAC_MSB:0]    dac_in;

	// Signed to offset binary, left-justified into the DAC width
	assign dac_in = {~core_audio[8], core_audio[7:0], {(DAC_MSB-8){1'b0}}};

	// ========================================================================
	// Clocking
	// ========================================================================
	clock_enables u_clock_enables (
		.clk_sys (clk_sys),
		.rst     (rst),
		.ce_6m   (ce_6m),
		.ce_4m   (ce_4m)
	);

	// ========================================================================
	// Input path
	// ========================================================================
	key_latch u_key_latch (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.key_strobe  (key_strobe),
		.key_code    (key_code),
		.key_pressed (key_pressed),
		.buttons     (buttons)
	);

	control_mapper u_control_mapper (
		.clk_sys (clk_sys),
		.rst     (rst),
		.buttons (buttons),
		.joy0    (joy0),
		.joy1    (joy1),
		.rotate  (rotate),
		.in0_n   (in0_n),
		.in1_n   (in1_n)
	);

	// ========================================================================
	// Video and audio
	// ========================================================================
	video_blank u_video_blank (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.pix_in     (core_pixel),
		.timing_in  (core_timing),
		.scanlines  (scanlines),
		.pix_out    (pix_out),
		.timing_out (timing_out)
	);

	sigma_delta_dac #(
		.DAC_MSB (DAC_MSB)
	) u_sigma_delta_dac (
		.clk_sys (clk_sys),
		.rst     (rst),
		.dac_in  (dac_in),
		.dac_out (audio_out)
	);

endmodule

// File: tb/cabinet_checker.sv
// Cabinet I/O checker
// Watches the DUT ports, models the expected outputs and counts errors

`timescale 1ns/10ps

module cabinet_checker #(
	parameter int DAC_MSB = 15
) (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  logic                  key_strobe,
	input  logic [7:0]            key_code,
	input  logic                  key_pressed,
	input  input_pkg::joystick_t  joy0,
	input  input_pkg::joystick_t  joy1,
	input  logic                  rotate,
	input  av_pkg::scanline_e     scanlines,
	input  av_pkg::core_pixel_t   core_pixel,
	input  av_pkg::video_timing_t core_timing,
	input  logic signed [8:0]     core_audio,
	input  logic                  audio_win,
	input  logic [95:0]           test_name,
	input  logic                  ce_6m,
	input  logic                  ce_4m,
	input  logic [7:0]            in0_n,
	input  logic [7:0]            in1_n,
	input  av_pkg::core_pixel_t   pix_out,
	input  av_pkg::video_timing_t timing_out,
	input  logic                  audio_out,
	output int                    mismatches,
	output int                    faults
);

	input_pkg::buttons_t   kb;
	logic [7:0]            exp_in0, exp_in1;
	av_pkg::core_pixel_t   exp_pix;
	av_pkg::video_timing_t exp_tim, tim_d;
	logic                  odd, armed, rst_q, win_d;
	int                    gap6, gap4, ones;

	function automatic logic [2:0] scale(input logic [2:0] c, input av_pkg::scanline_e lvl);
		case (lvl)
			av_pkg::pct25: scale = c - (c >> 2); // Three quarters
			av_pkg::pct50: scale = c >> 1;
			av_pkg::pct75: scale = c >> 2;
			default:       scale = c;
		endcase
	endfunction

	task automatic report_value(input string what, input logic [15:0] exp, input logic [15:0] act);
		mismatches++;
		$display("MISMATCH %0s %0s: expected %0h actual %0h", test_name, what, exp, act);
	endtask

	task automatic report_fault(input string msg);
		faults++;
		$display("ERROR in %0s: %0s", test_name, msg);
	endtask

	initial begin
		mismatches = 0;
		faults     = 0;
		armed      = 1'b0;
	end

	// ========================================================================
	// Reference model, updated on the same edge as the DUT
	// ========================================================================
	always @(posedge clk_sys) begin : model
		logic       up, dn, lf, rt, fire;
		logic [2:0] b3;
		longint     dac;
		longint     exp_ones;
		up   = kb.up | joy0.up | joy1.up;
		dn   = kb.down | joy0.down | joy1.down;
		lf   = kb.left | joy0.left | joy1.left;
		rt   = kb.right | joy0.right | joy1.right;
		fire = kb.fire1 | joy0.fire1 | joy1.fire1;
		b3   = scale({1'b0, core_pixel.blue}, scanlines);
		rst_q <= rst;
		win_d <= audio_win;
		if (rst) begin
			if (rst_q && (ce_6m || ce_4m))
				report_fault("clock enable high during reset");
			armed   <= 1'b1;
			kb      <= '0;
			exp_in0 <= 8'hff;
			exp_in1 <= 8'hff;
			exp_pix <= '0;
			exp_tim <= '0;
			tim_d   <= '0;
			odd     <= 1'b0;
			gap6    <= 0;
			gap4    <= 0;
			ones    <= 0;
		end else begin
			if (key_strobe) begin
				case (key_code)
					input_pkg::key_up:    kb.up     <= key_pressed;
					input_pkg::key_down:  kb.down   <= key_pressed;
					input_pkg::key_left:  kb.left   <= key_pressed;
					input_pkg::key_right: kb.right  <= key_pressed;
					input_pkg::key_esc:   kb.coin   <= key_pressed;
					input_pkg::key_f1:    kb.start1 <= key_pressed;
					input_pkg::key_f2:    kb.start2 <= key_pressed;
					input_pkg::key_ctrl:  kb.fire3  <= key_pressed;
					input_pkg::key_alt:   kb.fire2  <= key_pressed;
					input_pkg::key_space: kb.fire1  <= key_pressed;
					default: ;
				endcase
			end
			// Rotated monitor: up<-left, down<-right, left<-down, right<-up
			exp_in0 <= rotate ? ~{2'b00, kb.coin, fire, dn, rt, lf, up}
			                  : ~{2'b00, kb.coin, fire, rt, up, dn, lf};
			exp_in1 <= ~{1'b0, kb.start2, kb.start1, 5'b00000};
			tim_d   <= core_timing;
			exp_tim <= core_timing;
			if (core_timing.vsync && !tim_d.vsync)
				odd <= 1'b0;
			else if (core_timing.hsync && !tim_d.hsync)
				odd <= ~odd;
			if (core_timing.hblank || core_timing.vblank)
				exp_pix <= '0;
			else if (odd)
				exp_pix <= {scale(core_pixel.red, scanlines),
				            scale(core_pixel.green, scanlines), b3[1:0]};
			else
				exp_pix <= core_pixel;
			// Enable spacing, counted from the sampled strobe
			if (ce_6m) begin
				if (gap6 != 4)
					report_fault($sformatf("ce_6m spacing %0d cycles, not 4", gap6));
				gap6 <= 1;
			end else begin
				if (gap6 == 4)
					report_fault("ce_6m missing after 4 cycles");
				gap6 <= gap6 + 1;
			end
			if (ce_4m) begin
				if (gap4 != 6)
					report_fault($sformatf("ce_4m spacing %0d cycles, not 6", gap4));
				gap4 <= 1;
			end else begin
				if (gap4 == 6)
					report_fault("ce_4m missing after 6 cycles");
				gap4 <= gap4 + 1;
			end
			// Density of ones over the audio window
			if (audio_win)
				ones <= ones + int'(audio_out);
			else if (win_d) begin
				// Offset binary is the signed sample plus half of the 9-bit range
				dac      = (longint'(core_audio) + 256) << (DAC_MSB - 8);
				exp_ones = (dac * 4096) >> (DAC_MSB + 1);
				if (ones > exp_ones + 2 || ones < exp_ones - 2)
					report_value("audio ones", 16'(exp_ones), 16'(ones));
				ones <= 0;
			end
		end
	end

	// Outputs are stable on the falling edge
	always @(negedge clk_sys) begin
		if (armed) begin
			if (in0_n !== exp_in0)
				report_value("in0_n", 16'(exp_in0), 16'(in0_n));
			if (in1_n !== exp_in1)
				report_value("in1_n", 16'(exp_in1), 16'(in1_n));
			if (pix_out !== exp_pix)
				report_value("pix_out", 16'(exp_pix), 16'(pix_out));
			if (timing_out !== exp_tim)
				report_value("timing_out", 16'(exp_tim), 16'(timing_out));
			if (rst_q && audio_out !== 1'b0)
				report_fault("audio_out is not low during reset");
		end
	end

endmodule

// File: tb/tb_cabinet_io.sv
// Cabinet I/O testbench
// Clock, reset, stimulus table applied row by row, and run watchdog

`timescale 1ns/10ps

module tb_cabinet_io;

	localparam int DAC_MSB = 15;

	typedef struct packed {
		logic [95:0] name;
		logic        key_en;
		logic [7:0]  code;
		logic        pressed;
		logic [7:0]  j0;
		logic [7:0]  j1;
		logic        rot;
		logic [1:0]  sl;
		logic        rand_pix;
		logic [3:0]  tim;      // hsync, vsync, hblank, vblank
		logic [8:0]  aud;
		logic        win;      // Count audio ones over 4096 cycles
	} row_t;

	logic                  clk_sys, rst, key_strobe, key_pressed, rotate, audio_win;
	logic [7:0]            key_code;
	input_pkg::joystick_t  joy0, joy1;
	av_pkg::scanline_e     scanlines;
	av_pkg::core_pixel_t   core_pixel, pix_out;
	av_pkg::video_timing_t core_timing, timing_out;
	logic signed [8:0]     core_audio;
	logic [95:0]           test_name;
	logic                  ce_6m, ce_4m, audio_out;
	logic [7:0]            in0_n, in1_n;
	int                    mismatches, faults, seed;
	row_t                  rows[$];
	logic [7:0]            key_list[10];

	always #50 clk_sys = ~clk_sys;

	cabinet_io_top #(.DAC_MSB(DAC_MSB)) UUT (
		.clk_sys(clk_sys), .rst(rst), .key_strobe(key_strobe), .key_code(key_code),
		.key_pressed(key_pressed), .joy0(joy0), .joy1(joy1), .rotate(rotate),
		.scanlines(scanlines), .core_pixel(core_pixel), .core_timing(core_timing),
		.core_audio(core_audio), .ce_6m(ce_6m), .ce_4m(ce_4m), .in0_n(in0_n),
		.in1_n(in1_n), .pix_out(pix_out), .timing_out(timing_out), .audio_out(audio_out)
	);

	cabinet_checker #(.DAC_MSB(DAC_MSB)) u_checker (
		.clk_sys(clk_sys), .rst(rst), .key_strobe(key_strobe), .key_code(key_code),
		.key_pressed(key_pressed), .joy0(joy0), .joy1(joy1), .rotate(rotate),
		.scanlines(scanlines), .core_pixel(core_pixel), .core_timing(core_timing),
		.core_audio(core_audio), .audio_win(audio_win), .test_name(test_name),
		.ce_6m(ce_6m), .ce_4m(ce_4m), .in0_n(in0_n), .in1_n(in1_n), .pix_out(pix_out),
		.timing_out(timing_out), .audio_out(audio_out),
		.mismatches(mismatches), .faults(faults)
	);

	task automatic add_row(input logic [95:0] name, input logic key_en, input logic [7:0] code,
		input logic pressed, input logic [7:0] j0, input logic [7:0] j1, input logic rot,
		input logic [1:0] sl, input logic rand_pix, input logic [3:0] tim,
		input logic [8:0] aud, input logic win);
		row_t r;
		r = {name, key_en, code, pressed, j0, j1, rot, sl, rand_pix, tim, aud, win};
		rows.push_back(r);
	endtask

	// ========================================================================
	// Stimulus table
	// ========================================================================
	task automatic build_table();
		logic [8:0] aud_vals[4];
		aud_vals = '{9'h100, 9'h000, 9'h0ff, 9'h180};
		for (int i = 0; i < 10; i++) begin
			add_row("key_press", 1, key_list[i], 1, 8'h00, 8'h00, 1, 0, 0, 0, 0, 0);
			add_row("key_release", 1, key_list[i], 0, 8'h00, 8'h00, 1, 0, 0, 0, 0, 0);
		end
		add_row("key_unknown", 1, 8'h1c, 1, 8'h00, 8'h00, 1, 0, 0, 0, 0, 0);
		add_row("joy0_up_rot", 0, 0, 0, 8'h08, 8'h00, 1, 0, 0, 0, 0, 0);
		add_row("joy0_up_turn", 0, 0, 0, 8'h08, 8'h00, 0, 0, 0, 0, 0, 0);
		add_row("joy1_rt_turn", 0, 0, 0, 8'h00, 8'h01, 0, 0, 0, 0, 0, 0);
		add_row("joy1_lf_turn", 0, 0, 0, 8'h00, 8'h02, 0, 0, 0, 0, 0, 0);
		add_row("joy0_dn_rot", 0, 0, 0, 8'h04, 8'h00, 1, 0, 0, 0, 0, 0);
		add_row("joy0_fire", 0, 0, 0, 8'h10, 8'h00, 1, 0, 0, 0, 0, 0);
		add_row("joy1_fire", 0, 0, 0, 8'h00, 8'h10, 0, 0, 0, 0, 0, 0);
		add_row("joy_idle", 0, 0, 0, 8'h00, 8'h00, 1, 0, 0, 0, 0, 0);
		for (int lvl = 0; lvl < 4; lvl++) begin
			add_row("vsync", 0, 0, 0, 0, 0, 1, 2'(lvl), 1, 4'b0101, 0, 0);
			add_row("even_line", 0, 0, 0, 0, 0, 1, 2'(lvl), 1, 4'b0000, 0, 0);
			add_row("hsync", 0, 0, 0, 0, 0, 1, 2'(lvl), 1, 4'b1010, 0, 0);
			add_row("odd_line", 0, 0, 0, 0, 0, 1, 2'(lvl), 1, 4'b0000, 0, 0);
			add_row("hblank", 0, 0, 0, 0, 0, 1, 2'(lvl), 1, 4'b0010, 0, 0);
			add_row("vblank", 0, 0, 0, 0, 0, 1, 2'(lvl), 1, 4'b0001, 0, 0);
		end
		for (int i = 0; i < 4; i++)
			add_row("audio", 0, 0, 0, 0, 0, 1, 0, 0, 0, aud_vals[i], 1);
	endtask

	initial begin
		clk_sys     = 1'b0;
		rst         = 1'b1;
		key_strobe  = 1'b0;
		key_code    = 8'h00;
		key_pressed = 1'b0;
		joy0        = '0;
		joy1        = '0;
		rotate      = 1'b1;
		scanlines   = av_pkg::off;
		core_pixel  = '0;
		core_timing = '0;
		core_audio  = '0;
		audio_win   = 1'b0;
		test_name   = "reset";
		seed        = 32'h48ad45db;
		key_list    = '{input_pkg::key_up, input_pkg::key_down, input_pkg::key_left,
		                input_pkg::key_right, input_pkg::key_esc, input_pkg::key_f1,
		                input_pkg::key_f2, input_pkg::key_ctrl, input_pkg::key_alt,
		                input_pkg::key_space};
		build_table();
		repeat (10) @(negedge clk_sys);
		rst = 1'b0;
		repeat (8) @(negedge clk_sys); // Let the enables settle into their rhythm
		foreach (rows[i]) begin
			@(negedge clk_sys);
			test_name   = rows[i].name;
			key_code    = rows[i].code;
			key_pressed = rows[i].pressed;
			key_strobe  = rows[i].key_en;
			joy0        = rows[i].j0;
			joy1        = rows[i].j1;
			rotate      = rows[i].rot;
			scanlines   = av_pkg::scanline_e'(rows[i].sl);
			core_timing = rows[i].tim;
			core_audio  = rows[i].aud;
			core_pixel  = rows[i].rand_pix ? 8'($random(seed)) : 8'h00;
			@(negedge clk_sys);
			key_strobe = 1'b0;
			if (rows[i].win) begin
				audio_win = 1'b1;
				repeat (4096) @(negedge clk_sys);
				audio_win = 1'b0;
			end else
				repeat (3) @(negedge clk_sys);
		end
		repeat (4) @(negedge clk_sys);
		$display("Errors: %0d mismatches, %0d other failures", mismatches, faults);
		if (mismatches == 0 && faults == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// Watchdog sized from the table
	initial begin
		#1;
		repeat (rows.size() * 300 + 2000) @(posedge clk_sys);
		$display("Watchdog expired before the stimulus table finished");
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: flist.f
common/input_pkg.sv
common/av_pkg.sv
design/clock_enables.sv
input/key_latch.sv
input/control_mapper.sv
av/video_blank.sv
av/sigma_delta_dac.sv
design/cabinet_io_top.sv
tb/cabinet_checker.sv
tb/tb_cabinet_io.sv

// File: Makefile
# Verilator build for the cabinet I/O testbench

VERILATOR ?= verilator
TOP       ?= tb_cabinet_io
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
